// File: design/rpRegPkg.sv
////////////////////////////////////////////////////////////////////////////
// Disk drive register formats, bit positions and function codes.
// Imported by the drive blocks that pack or decode register words.
////////////////////////////////////////////////////////////////////////////

package rpRegPkg;

   // Offset register as seen by the controller
   typedef struct packed {
      logic [2:0] unused15;
      logic       fmt22;
      logic       eci;
      logic       hci;
      logic [1:0] unused9;
      logic       ofd;
      logic [6:0] ofs;
   } rpOfReg;

   // Control word view of a bus data word
   typedef struct packed {
      logic [29:0] unused35;
      logic [4:0]  fn;
      logic        go;
   } rpCs1Word;

   // Offset view of a bus data word, OF layout in the low half
   typedef struct packed {
      logic [19:0] unused35;
      rpOfReg      ofv;
   } rpOfWord;

   // One 36-bit data word, decoded per target register
   typedef union packed {
      rpCs1Word cs1;
      rpOfWord  ofw;
   } rpDataWord;

   // Error register 1, only RMR and ILF are kept
   typedef struct packed {
      logic [12:0] unused15;
      logic        rmr;
      logic        unused1;
      logic        ilf;
   } rpEr1Reg;

   // Function codes, CS1 bits 5:1
   localparam logic [4:0] FN_NOP    = 5'o00;
   localparam logic [4:0] FN_DRVCLR = 5'o04;
   localparam logic [4:0] FN_CENTER = 5'o07;
   localparam logic [4:0] FN_PRESET = 5'o10;

   // Drive status bit positions
   localparam int DS_ERR = 14;
   localparam int DS_DPR = 8;
   localparam int DS_DRY = 7;
   localparam int DS_VV  = 6;

endpackage

// File: design/rpBusPkg.sv
////////////////////////////////////////////////////////////////////////////
// Register bus write transaction, drive register addresses and busy time.
////////////////////////////////////////////////////////////////////////////

package rpBusPkg;

   // One-cycle write strobe from the controller
   typedef struct packed {
      logic              valid;
      logic [3:0]        addr;
      rpRegPkg::rpDataWord data;
   } rpWrite;

   // Drive register addresses
   localparam logic [3:0] ADDR_CS1 = 4'd0;
   localparam logic [3:0] ADDR_DS  = 4'd1;
   localparam logic [3:0] ADDR_ER1 = 4'd2;
   localparam logic [3:0] ADDR_OF  = 4'd9;

   // Cycles the drive reports not ready after PRESET or CENTER
   localparam int BUSY_CYCLES = 8;

   // Width of the busy down-counter
   localparam int BUSY_WIDTH = $clog2(BUSY_CYCLES + 1);

endpackage

// File: design/rpCmdDecode.sv
////////////////////////////////////////////////////////////////////////////
// Register write decoder for the drive: command pulses, busy timing and
// refusal of writes while the drive is not ready.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rpCmdDecode
(
   input  logic            clk,
   input  logic            rst,
   input  rpBusPkg::rpWrite wr,
   output logic            clr,
   output logic            center,
   output logic            preset,
   output logic            ofWrite,
   output logic            rmrSet,
   output logic            ilfSet,
   output logic            dry
);

   import rpRegPkg::*;
   import rpBusPkg::*;

   logic [BUSY_WIDTH-1:0] busyCnt;
   logic                  cs1Sel;
   logic                  ofSel;
   logic [4:0]            fn;
   logic                  go;

   // Address match, qualified by the strobe
   assign cs1Sel = wr.valid && (wr.addr == ADDR_CS1);
   assign ofSel  = wr.valid && (wr.addr == ADDR_OF);

   // Control word view of the data
   assign fn = wr.data.cs1.fn;
   assign go = wr.data.cs1.go;

   // Ready whenever the busy timer has run out
   assign dry = (busyCnt == '0);

   ////////////////////////////////////////////////////////////////////////
   // Command and write qualification
   ////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      clr     = 1'b0;
      center  = 1'b0;
      preset  = 1'b0;
      ofWrite = 1'b0;
      rmrSet  = 1'b0;
      ilfSet  = 1'b0;

      if (cs1Sel)
      begin
         // Drive clear gets through even when busy
         if (go && (fn == FN_DRVCLR))
            clr = 1'b1;
         else if (!dry)
            rmrSet = 1'b1;
         else if (go && (fn != FN_NOP))
         begin
            case (fn)
               FN_CENTER: center = 1'b1;
               FN_PRESET: preset = 1'b1;
               // Anything else is not supported by this drive
               default:   ilfSet = 1'b1;
            endcase
         end
      end

      // Offset load only when ready
      if (ofSel)
      begin
         if (dry)
            ofWrite = 1'b1;
         else
            rmrSet = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Busy timer
   ////////////////////////////////////////////////////////////////////////

   // Loaded at the command edge, ready again after BUSY_CYCLES edges
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         busyCnt <= '0;
      else if (center || preset)
         busyCnt <= BUSY_WIDTH'(BUSY_CYCLES);
      else if (!dry)
         busyCnt <= busyCnt - 1'b1;
   end

endmodule

// File: design/rpOffset.sv
////////////////////////////////////////////////////////////////////////////
// Drive offset register. Loaded from the bus when the decoder allows it,
// cleared in parts by PRESET, DRIVE CLEAR and RETURN TO CENTERLINE.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rpOffset
(
   input  logic                clk,
   input  logic                rst,
   input  logic                clr,
   input  logic                center,
   input  logic                preset,
   input  rpRegPkg::rpDataWord dataIn,
   input  logic                ofWrite,
   output rpRegPkg::rpOfReg    ofReg
);

   import rpRegPkg::*;

   rpOfReg ofIn;
   logic   fmt22Q;
   logic   eciQ;
   logic   hciQ;
   logic   ofdQ;
   logic   [6:0] ofsQ;

   // Offset view of the incoming data word
   assign ofIn = dataIn.ofw.ofv;

   ////////////////////////////////////////////////////////////////////////
   // Format and inhibit bits
   ////////////////////////////////////////////////////////////////////////

   // Preset wins over a load
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         fmt22Q <= 1'b0;
         eciQ   <= 1'b0;
         hciQ   <= 1'b0;
      end
      else if (preset)
      begin
         fmt22Q <= 1'b0;
         eciQ   <= 1'b0;
         hciQ   <= 1'b0;
      end
      else if (ofWrite)
      begin
         fmt22Q <= ofIn.fmt22;
         eciQ   <= ofIn.eci;
         hciQ   <= ofIn.hci;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Head offset direction and amount
   ////////////////////////////////////////////////////////////////////////

   // Drive clear or centerline puts the heads back on track
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         ofdQ <= 1'b0;
         ofsQ <= '0;
      end
      else if (clr || center)
      begin
         ofdQ <= 1'b0;
         ofsQ <= '0;
      end
      else if (ofWrite)
      begin
         ofdQ <= ofIn.ofd;
         ofsQ <= ofIn.ofs;
      end
   end

   // Unused bits always read as zero
   always_comb
   begin
      ofReg       = '0;
      ofReg.fmt22 = fmt22Q;
      ofReg.eci   = eciQ;
      ofReg.hci   = hciQ;
      ofReg.ofd   = ofdQ;
      ofReg.ofs   = ofsQ;
   end

endmodule

// File: design/rpErrorReg.sv
////////////////////////////////////////////////////////////////////////////
// Drive error register 1. Sticky flags set by decoder pulses and
// cleared by DRIVE CLEAR.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rpErrorReg
(
   input  logic              clk,
   input  logic              rst,
   input  logic              clr,
   input  logic              rmrSet,
   input  logic              ilfSet,
   output rpRegPkg::rpEr1Reg er1
);

   import rpRegPkg::*;

   logic rmrQ;
   logic ilfQ;

   ////////////////////////////////////////////////////////////////////////
   // Error flags
   ////////////////////////////////////////////////////////////////////////

   // Register modification refused, clear has priority
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rmrQ <= 1'b0;
      else if (clr)
         rmrQ <= 1'b0;
      else if (rmrSet)
         rmrQ <= 1'b1;
   end

   // Illegal function
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         ilfQ <= 1'b0;
      else if (clr)
         ilfQ <= 1'b0;
      else if (ilfSet)
         ilfQ <= 1'b1;
   end

   // Pack into ER1 layout, other bits zero
   always_comb
   begin
      er1     = '0;
      er1.rmr = rmrQ;
      er1.ilf = ilfQ;
   end

endmodule

// File: design/rpStatusRead.sv
////////////////////////////////////////////////////////////////////////////
// Volume valid flag, drive status word and the combinational read mux
// for the drive register bus.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rpStatusRead
(
   input  logic              clk,
   input  logic              rst,
   input  logic              preset,
   input  logic              dry,
   input  rpRegPkg::rpEr1Reg er1,
   input  rpRegPkg::rpOfReg  ofReg,
   input  logic [3:0]        rdAddr,
   output logic [15:0]       rdData
);

   import rpRegPkg::*;
   import rpBusPkg::*;

   logic        vvQ;
   logic [15:0] dsWord;

   // Volume valid, only reset takes it away
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         vvQ <= 1'b0;
      else if (preset)
         vvQ <= 1'b1;
   end

   // Status word, DPR is tied on for a present drive
   always_comb
   begin
      dsWord         = '0;
      dsWord[DS_ERR] = |er1;
      dsWord[DS_DPR] = 1'b1;
      dsWord[DS_DRY] = dry;
      dsWord[DS_VV]  = vvQ;
   end

   ////////////////////////////////////////////////////////////////////////
   // Read multiplexer
   ////////////////////////////////////////////////////////////////////////

   // CS1 is write-only here
   always_comb
   begin
      case (rdAddr)
         ADDR_CS1: rdData = '0;
         ADDR_DS:  rdData = dsWord;
         ADDR_ER1: rdData = er1;
         ADDR_OF:  rdData = ofReg;
         default:  rdData = '0;
      endcase
   end

endmodule

// File: design/rpDrive.sv
////////////////////////////////////////////////////////////////////////////
// Drive register top level. Hooks the decoder, offset, error and status
// blocks to the controller write strobe and read port.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rpDrive
(
   input  logic             clk,
   input  logic             rst,
   input  rpBusPkg::rpWrite wr,
   input  logic [3:0]       rdAddr,
   output logic [15:0]      rdData
);

   import rpRegPkg::*;

   // Decoder pulses and ready level
   logic   clr;
   logic   center;
   logic   preset;
   logic   ofWrite;
   logic   rmrSet;
   logic   ilfSet;
   logic   dry;

   // Register state toward the read side
   rpOfReg  ofReg;
   rpEr1Reg er1;

   rpCmdDecode i_cmdDecode
   (
      .clk     (clk),
      .rst     (rst),
      .wr      (wr),
      .clr     (clr),
      .center  (center),
      .preset  (preset),
      .ofWrite (ofWrite),
      .rmrSet  (rmrSet),
      .ilfSet  (ilfSet),
      .dry     (dry)
   );

   rpOffset i_offset
   (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .center  (center),
      .preset  (preset),
      .dataIn  (wr.data),
      .ofWrite (ofWrite),
      .ofReg   (ofReg)
   );

   rpErrorReg i_errorReg
   (
      .clk    (clk),
      .rst    (rst),
      .clr    (clr),
      .rmrSet (rmrSet),
      .ilfSet (ilfSet),
      .er1    (er1)
   );

   // Read port
   rpStatusRead i_statusRead
   (
      .clk    (clk),
      .rst    (rst),
      .preset (preset),
      .dry    (dry),
      .er1    (er1),
      .ofReg  (ofReg),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

endmodule

// File: sim/rpClkGen.sv
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset source for the drive register model.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rpClkGen
(
   output logic clk,
   output logic rst
);

   // 10 ns period
   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset held over the first 4 rising edges
   initial
   begin
      rst = 1'b1;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

// File: sim/rpDrive_sva.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent checks on the command decoder, bound into every rpCmdDecode.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rpDriveSva
(
   input logic clk,
   input logic rst,
   input logic clr,
   input logic center,
   input logic preset,
   input logic ilfSet,
   input logic ofWrite,
   input logic dry
);

   import rpBusPkg::*;

   // At most one command outcome per write
   cmdOneHot: assert property (@(posedge clk) disable iff (rst)
      $onehot0({clr, center, preset, ilfSet}))
      else $error("Command pulses overlap");

   // Busy starts on the cycle after the command
   busyStart: assert property (@(posedge clk) disable iff (rst)
      (center || preset) |=> !dry)
      else $error("Drive still ready after PRESET or CENTER");

   // Ready seen again after exactly BUSY_CYCLES busy samples
   busyLength: assert property (@(posedge clk) disable iff (rst)
      $rose(dry) |-> $past(center || preset, BUSY_CYCLES + 1))
      else $error("Busy period has the wrong length");

   // No offset load while busy
   ofWhenReady: assert property (@(posedge clk) disable iff (rst)
      ofWrite |-> dry)
      else $error("Offset write accepted while busy");

endmodule

bind rpCmdDecode rpDriveSva i_sva
(
   .clk     (clk),
   .rst     (rst),
   .clr     (clr),
   .center  (center),
   .preset  (preset),
   .ilfSet  (ilfSet),
   .ofWrite (ofWrite),
   .dry     (dry)
);

// File: sim/rpDriveTb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the drive registers. Runs the operations of the stimulus
// file in order and checks every read against its expected value.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module rpDriveTb;

   import rpRegPkg::*;
   import rpBusPkg::*;

   // Stimulus table size and wait limits in cycles
   localparam int MAX_OPS  = 64;
   localparam int WAIT_MAX = 50;
   localparam int RST_MAX  = 20;

   // Operation codes of the stimulus file
   localparam logic [3:0] OP_IDLE  = 4'h0;
   localparam logic [3:0] OP_WRITE = 4'h1;
   localparam logic [3:0] OP_READ  = 4'h2;
   localparam logic [3:0] OP_WAIT  = 4'h3;
   localparam logic [3:0] OP_END   = 4'h4;

   logic        clk;
   logic        rst;
   rpWrite      wr;
   logic [3:0]  rdAddr;
   logic [15:0] rdData;

   // Four words per operation: op, addr, data, expected read
   logic [35:0] stim [0:4*MAX_OPS-1];

   int errCount;
   int checkCount;
   bit timedOut;

   rpClkGen i_clkGen
   (
      .clk (clk),
      .rst (rst)
   );

   rpDrive i_dut
   (
      .clk    (clk),
      .rst    (rst),
      .wr     (wr),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

   ////////////////////////////////////////////////////////////////////////
   // Bus helpers
   ////////////////////////////////////////////////////////////////////////

   // Read one register mid-cycle and compare
   task automatic checkRead(input logic [3:0] addr, input logic [15:0] expData);
      rdAddr = addr;
      #4;
      checkCount++;
      assert (rdData === expData)
      else
      begin
         errCount++;
         $display("Fail at %0t ns: rdData at address %h expected %h, got %h",
                  $time, addr, expData, rdData);
      end
   endtask

   // Poll DS until DRY, one sample per cycle
   task automatic waitReady(output bit ok);
      int cycles;
      cycles = 0;
      rdAddr = ADDR_DS;
      #4;
      while (!rdData[DS_DRY] && cycles < WAIT_MAX)
      begin
         @(posedge clk);
         #5;
         cycles++;
      end
      ok = rdData[DS_DRY];
   endtask

   // Reset release, sampled just after each edge
   task automatic waitResetDone(output bit ok);
      int cycles;
      cycles = 0;
      // Reset source drives rst from time zero
      #1;
      while (rst && cycles < RST_MAX)
      begin
         @(posedge clk);
         #1;
         cycles++;
      end
      ok = !rst;
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////

   initial
   begin : mainFlow
      bit          ok;
      bit          done;
      int          idx;
      logic [3:0]  opCode;
      logic [3:0]  addr;
      logic [35:0] data;
      logic [15:0] expData;

      wr         = '0;
      rdAddr     = '0;
      errCount   = 0;
      checkCount = 0;
      timedOut   = 1'b0;
      done       = 1'b0;
      idx        = 0;

      $readmemh("sim/rpDrive_input.txt", stim);

      waitResetDone(ok);
      if (!ok)
      begin
         timedOut = 1'b1;
         $display("Timeout: reset was not released after %0d cycles", RST_MAX);
      end

      while (ok && !done && idx < MAX_OPS)
      begin
         @(posedge clk);
         #1;
         opCode  = stim[4*idx][3:0];
         addr    = stim[4*idx+1][3:0];
         data    = stim[4*idx+2];
         expData = stim[4*idx+3][15:0];
         // Strobe lasts one cycle only
         wr = '0;
         case (opCode)
            OP_IDLE:
               rdAddr = '0;
            OP_WRITE:
            begin
               wr.valid = 1'b1;
               wr.addr  = addr;
               wr.data  = data;
            end
            OP_READ:
               checkRead(addr, expData);
            OP_WAIT:
            begin
               waitReady(ok);
               if (!ok)
               begin
                  timedOut = 1'b1;
                  $display("Timeout: DRY did not return within %0d cycles, entry %0d",
                           WAIT_MAX, idx);
               end
            end
            OP_END:
               done = 1'b1;
            default:
            begin
               errCount++;
               $display("Stimulus entry %0d holds an unknown operation", idx);
               done = 1'b1;
            end
         endcase
         idx++;
      end

      if (ok && !done)
      begin
         errCount++;
         $display("Stimulus file has no end marker");
      end

      @(posedge clk);
      $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errCount, timedOut);
      if (errCount == 0 && !timedOut)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// File: sim/rpDrive_input.txt
// Columns: op addr data expect, all hex. op 0 idle, 1 write, 2 read and check,
// 3 wait for DS DRY, 4 end. data is the 36-bit bus word, expect the 16-bit read.
2 1 000000000 0180  // DS after reset, DPR and DRY
2 2 000000000 0000
2 9 000000000 0000
2 5 000000000 0000  // unknown address
1 9 FFFFFFFFF 0000  // OF write while ready
2 9 000000000 1CFF
1 0 00000000F 0000  // RETURN TO CENTERLINE
2 1 000000000 0100
2 9 000000000 1C00
1 9 000000055 0000  // OF write while busy
2 9 000000000 1C00
2 2 000000000 0004
2 1 000000000 4100
3 1 000000000 0000
2 1 000000000 4180
1 0 000000007 0000  // function 03 with GO
2 2 000000000 0005
1 9 000001CA5 0000
2 9 000000000 1CA5
1 0 000000009 0000  // DRIVE CLEAR
2 2 000000000 0000
2 1 000000000 0180
2 9 000000000 1C00
1 0 000000011 0000  // PRESET
2 1 000000000 0140
2 9 000000000 0000
3 1 000000000 0000
2 1 000000000 01C0
1 0 000000009 0000  // DRIVE CLEAR keeps VV
0 0 000000000 0000
2 1 000000000 01C0
4 0 000000000 0000

// File: filelist.f
design/rpRegPkg.sv
design/rpBusPkg.sv
design/rpCmdDecode.sv
design/rpOffset.sv
design/rpErrorReg.sv
design/rpStatusRead.sv
design/rpDrive.sv
sim/rpClkGen.sv
sim/rpDrive_sva.sv
sim/rpDriveTb.sv

// File: Makefile
# Verilator lint and simulation of the drive register model

VERILATOR ?= verilator
TOP       ?= rpDriveTb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
